// ==== logic/mem_axi_pkg.sv ====
// ######################################
// widths, fixed AXI field values and the
// memory window shared by the AXI memory
// port, its masters and the test memory
// ######################################

package mem_axi_pkg;

	typedef logic [63:0] addr_t;
	typedef logic [63:0] data_t;
	typedef logic [7:0]  strb_t;
	typedef logic [2:0]  bias_t;

	typedef logic [3:0] axi_id_t;
	typedef logic [7:0] axi_len_t;
	typedef logic [2:0] axi_size_t;
	typedef logic [1:0] axi_burst_t;
	typedef logic [1:0] axi_resp_t;

	// one ID for loads and stores with a single burst in flight
	localparam axi_id_t MEM_ID = 4'd1;

	localparam axi_size_t AXI_SIZE_DOUBLE = 3'b011;
	localparam axi_burst_t AXI_BURST_INCR = 2'b01;

	// len is beats minus one
	localparam axi_len_t AXI_LEN_SINGLE = 8'd0;
	localparam axi_len_t AXI_LEN_PAIR   = 8'd1;

	localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

	// core addresses start at zero and the bus window at MEM_BASE
	localparam addr_t MEM_BASE = 64'h0000_0000_8000_0000;

	localparam int MEM_WORDS   = 256;
	localparam int MEM_INDEX_W = 8;

endpackage

// ==== logic/mem_store_path.sv ====
// ######################################
// AXI write master for core stores; an
// unaligned store becomes a two-beat INCR
// burst with data and strobes split
// ######################################

`timescale 1ns/1ps

module mem_store_path (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   mem_wr_en,
	input  mem_axi_pkg::addr_t     addr_mem_wr,
	input  mem_axi_pkg::data_t     data_mem_wr,
	input  mem_axi_pkg::strb_t     strb_mem_wr,
	output logic                   store_pending,

	output logic                   awvalid,
	input  logic                   awready,
	output mem_axi_pkg::axi_id_t   awid,
	output mem_axi_pkg::addr_t     awaddr,
	output mem_axi_pkg::axi_len_t  awlen,
	output mem_axi_pkg::axi_size_t awsize,
	output mem_axi_pkg::axi_burst_t awburst,

	output logic                   wvalid,
	input  logic                   wready,
	output mem_axi_pkg::data_t     wdata,
	output mem_axi_pkg::strb_t     wstrb,
	output logic                   wlast,

	input  logic                   bvalid,
	input  mem_axi_pkg::axi_id_t   bid,
	input  mem_axi_pkg::axi_resp_t bresp,
	output logic                   bready
);
	import mem_axi_pkg::*;

	logic         busy;
	logic         wvalid_q;
	logic         beat;
	logic         wait_b;
	logic         pair;
	bias_t        bias;
	bias_t        bias_q;
	data_t        data_lo;
	data_t        data_hi;
	strb_t        strb_lo;
	strb_t        strb_hi;
	logic [127:0] data_wide;
	logic [15:0]  strb_wide;
	logic         aw_fire;
	logic         w_fire;
	logic         b_fire;

	assign bias = addr_mem_wr[2:0];

	assign awvalid = mem_wr_en & ~busy;
	assign awid    = MEM_ID;
	assign awaddr  = {addr_mem_wr[63:3], 3'b000} + MEM_BASE;
	assign awlen   = (bias == 3'd0) ? AXI_LEN_SINGLE : AXI_LEN_PAIR;
	assign awsize  = AXI_SIZE_DOUBLE;
	assign awburst = AXI_BURST_INCR;
	assign aw_fire = awvalid & awready;

	// bytes pushed past bit 63 spill into the second beat
	assign data_wide = {64'd0, data_mem_wr} << {bias, 3'b000};
	assign strb_wide = {8'd0, strb_mem_wr} << bias;

	assign pair   = (bias_q != 3'd0);
	assign wvalid = wvalid_q;
	assign wdata  = beat ? data_hi : data_lo;
	assign wstrb  = beat ? strb_hi : strb_lo;
	assign wlast  = wvalid_q & (beat | ~pair);
	assign w_fire = wvalid_q & wready;

	// slave answers OKAY only, so bresp carries nothing to act on
	assign bready = wait_b;
	assign b_fire = bvalid & bready & (bid == MEM_ID) & (bresp == AXI_RESP_OKAY);

	assign store_pending = mem_wr_en & ~b_fire;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			wvalid_q <= 1'b0;
			beat     <= 1'b0;
			wait_b   <= 1'b0;
		end else begin
			if (aw_fire) begin
				busy     <= 1'b1;
				wvalid_q <= 1'b1;
				beat     <= 1'b0;
			end
			if (w_fire) begin
				if (wlast) begin
					wvalid_q <= 1'b0;
					wait_b   <= 1'b1;
				end else begin
					beat <= 1'b1;
				end
			end
			if (b_fire) begin
				busy   <= 1'b0;
				wait_b <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (aw_fire) begin
			bias_q  <= bias;
			data_lo <= data_wide[63:0];
			data_hi <= data_wide[127:64];
			strb_lo <= strb_wide[7:0];
			strb_hi <= strb_wide[15:8];
		end
	end

endmodule

// ==== logic/mem_load_path.sv ====
// ######################################
// AXI read master for core loads; joins
// the two beats of an unaligned burst
// into one 64-bit result
// ######################################

`timescale 1ns/1ps

module mem_load_path (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   mem_rd_en,
	input  mem_axi_pkg::addr_t     addr_mem_rd,
	output mem_axi_pkg::data_t     data_mem_rd,
	output logic                   load_pending,

	output logic                   arvalid,
	input  logic                   arready,
	output mem_axi_pkg::axi_id_t   arid,
	output mem_axi_pkg::addr_t     araddr,
	output mem_axi_pkg::axi_len_t  arlen,
	output mem_axi_pkg::axi_size_t arsize,
	output mem_axi_pkg::axi_burst_t arburst,

	input  logic                   rvalid,
	input  mem_axi_pkg::axi_id_t   rid,
	input  mem_axi_pkg::data_t     rdata,
	input  mem_axi_pkg::axi_resp_t rresp,
	input  logic                   rlast,
	output logic                   rready
);
	import mem_axi_pkg::*;

	logic         busy;
	bias_t        bias_q;
	data_t        first_q;
	data_t        low_word;
	logic [127:0] joined;
	logic         ar_fire;
	logic         r_fire;
	logic         r_done;

	assign arvalid = mem_rd_en & ~busy;
	assign arid    = MEM_ID;
	assign araddr  = {addr_mem_rd[63:3], 3'b000} + MEM_BASE;
	assign arlen   = (addr_mem_rd[2:0] == 3'd0) ? AXI_LEN_SINGLE : AXI_LEN_PAIR;
	assign arsize  = AXI_SIZE_DOUBLE;
	assign arburst = AXI_BURST_INCR;
	assign ar_fire = arvalid & arready;

	assign rready = busy;
	assign r_fire = rvalid & rready & (rid == MEM_ID) & (rresp == AXI_RESP_OKAY);
	assign r_done = r_fire & rlast;

	assign load_pending = mem_rd_en & ~r_done;

	// an aligned load has one beat, which is the whole result
	assign low_word = (bias_q == 3'd0) ? rdata : first_q;

	// upper bytes of the first word land low, the last word fills the top
	assign joined      = {rdata, low_word} >> {bias_q, 3'b000};
	assign data_mem_rd = joined[63:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
		end else begin
			if (ar_fire) begin
				busy <= 1'b1;
			end else if (r_done) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ar_fire) begin
			bias_q <= addr_mem_rd[2:0];
		end
		if (r_fire & ~rlast) begin
			first_q <= rdata;
		end
	end

endmodule

// ==== logic/axi_sram_slave.sv ====
// ######################################
// AXI4 test memory, 256 x 64-bit words
// with byte strobes and INCR bursts;
// an LFSR inserts 0 to 3 wait cycles
// ######################################

`timescale 1ns/1ps

module axi_sram_slave (
	input  logic                   clk,
	input  logic                   rst_n,

	input  logic                   awvalid,
	output logic                   awready,
	input  mem_axi_pkg::axi_id_t   awid,
	input  mem_axi_pkg::addr_t     awaddr,
	input  mem_axi_pkg::axi_len_t  awlen,
	input  mem_axi_pkg::axi_size_t awsize,
	input  mem_axi_pkg::axi_burst_t awburst,

	input  logic                   wvalid,
	output logic                   wready,
	input  mem_axi_pkg::data_t     wdata,
	input  mem_axi_pkg::strb_t     wstrb,
	input  logic                   wlast,

	output logic                   bvalid,
	input  logic                   bready,
	output mem_axi_pkg::axi_id_t   bid,
	output mem_axi_pkg::axi_resp_t bresp,

	input  logic                   arvalid,
	output logic                   arready,
	input  mem_axi_pkg::axi_id_t   arid,
	input  mem_axi_pkg::addr_t     araddr,
	input  mem_axi_pkg::axi_len_t  arlen,
	input  mem_axi_pkg::axi_size_t arsize,
	input  mem_axi_pkg::axi_burst_t arburst,

	output logic                   rvalid,
	input  logic                   rready,
	output mem_axi_pkg::axi_id_t   rid,
	output mem_axi_pkg::data_t     rdata,
	output mem_axi_pkg::axi_resp_t rresp,
	output logic                   rlast
);
	import mem_axi_pkg::*;

	data_t                  mem [MEM_WORDS];
	logic [6:0]             lfsr;

	logic                   w_active;
	logic                   b_pending;
	addr_t                  w_addr;
	axi_len_t               w_len;
	axi_len_t               w_beat;
	axi_size_t              w_size;
	logic                   w_incr;
	axi_id_t                w_id;
	logic [1:0]             w_wait;
	logic [MEM_INDEX_W-1:0] w_idx;
	logic                   aw_fire;
	logic                   w_fire;
	logic                   w_end;
	logic                   b_fire;

	logic                   r_active;
	addr_t                  r_addr;
	axi_len_t               r_len;
	axi_len_t               r_beat;
	axi_size_t              r_size;
	logic                   r_incr;
	axi_id_t                r_id;
	logic [1:0]             r_wait;
	logic [MEM_INDEX_W-1:0] r_idx;
	logic                   ar_fire;
	logic                   r_fire;

	// write side
	assign awready = ~w_active & ~b_pending & (w_wait == 2'd0);
	assign wready  = w_active & (w_wait == 2'd0);
	assign aw_fire = awvalid & awready;
	assign w_fire  = wvalid & wready;
	assign w_end   = w_fire & (wlast | (w_beat == w_len));
	assign w_idx   = w_addr[MEM_INDEX_W+2:3];

	assign bvalid = b_pending;
	assign bid    = w_id;
	assign bresp  = AXI_RESP_OKAY;
	assign b_fire = bvalid & bready;

	// read side
	assign arready = ~r_active & (r_wait == 2'd0);
	assign ar_fire = arvalid & arready;
	assign r_idx   = r_addr[MEM_INDEX_W+2:3];

	assign rvalid = r_active & (r_wait == 2'd0);
	assign rid    = r_id;
	assign rdata  = mem[r_idx];
	assign rresp  = AXI_RESP_OKAY;
	assign rlast  = rvalid & (r_beat == r_len);
	assign r_fire = rvalid & rready;

	// x^7 + x^6 + 1
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lfsr <= 7'h4d;
		end else begin
			lfsr <= {lfsr[5:0], lfsr[6] ^ lfsr[5]};
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			w_active  <= 1'b0;
			b_pending <= 1'b0;
			w_beat    <= '0;
			w_wait    <= 2'd0;
			r_active  <= 1'b0;
			r_beat    <= '0;
			r_wait    <= 2'd0;
		end else begin
			// fresh wait count after every transfer
			if (aw_fire | w_fire | b_fire) begin
				w_wait <= lfsr[1:0];
			end else if (w_wait != 2'd0) begin
				w_wait <= w_wait - 2'd1;
			end
			if (aw_fire) begin
				w_active <= 1'b1;
				w_beat   <= '0;
			end else if (w_fire) begin
				w_beat <= w_beat + 8'd1;
			end
			if (w_end) begin
				w_active  <= 1'b0;
				b_pending <= 1'b1;
			end
			if (b_fire) begin
				b_pending <= 1'b0;
			end

			if (ar_fire | r_fire) begin
				r_wait <= lfsr[4:3];
			end else if (r_wait != 2'd0) begin
				r_wait <= r_wait - 2'd1;
			end
			if (ar_fire) begin
				r_active <= 1'b1;
				r_beat   <= '0;
			end else if (r_fire) begin
				r_beat <= r_beat + 8'd1;
				if (rlast) begin
					r_active <= 1'b0;
				end
			end
		end
	end

	// burst address and attributes, local to the window
	always_ff @(posedge clk) begin
		if (aw_fire) begin
			w_addr <= awaddr - MEM_BASE;
			w_len  <= awlen;
			w_size <= awsize;
			w_incr <= (awburst == AXI_BURST_INCR);
			w_id   <= awid;
		end else if (w_fire & w_incr) begin
			w_addr <= w_addr + (addr_t'(1) << w_size);
		end
		if (ar_fire) begin
			r_addr <= araddr - MEM_BASE;
			r_len  <= arlen;
			r_size <= arsize;
			r_incr <= (arburst == AXI_BURST_INCR);
			r_id   <= arid;
		end else if (r_fire & r_incr) begin
			r_addr <= r_addr + (addr_t'(1) << r_size);
		end
	end

	always_ff @(posedge clk) begin
		if (w_fire) begin
			for (int i = 0; i < 8; i++) begin
				if (wstrb[i]) begin
					mem[w_idx][i*8 +: 8] <= wdata[i*8 +: 8];
				end
			end
		end
	end

endmodule

// ==== logic/mem_subsys_top.sv ====
// ######################################
// memory-stage bus port: store and load
// masters on a shared AXI test memory;
// stall_mem holds the core until done
// ######################################

`timescale 1ns/1ps

module mem_subsys_top (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               mem_wr_en,
	input  logic               mem_rd_en,
	input  mem_axi_pkg::addr_t addr_mem_wr,
	input  mem_axi_pkg::addr_t addr_mem_rd,
	input  mem_axi_pkg::data_t data_mem_wr,
	input  mem_axi_pkg::strb_t strb_mem_wr,
	output mem_axi_pkg::data_t data_mem_rd,
	output logic               stall_mem
);
	import mem_axi_pkg::*;

	logic store_pending;
	logic load_pending;

	// write address and data
	logic       awvalid;
	logic       awready;
	axi_id_t    awid;
	addr_t      awaddr;
	axi_len_t   awlen;
	axi_size_t  awsize;
	axi_burst_t awburst;
	logic       wvalid;
	logic       wready;
	logic       wlast;
	data_t      wdata;
	strb_t      wstrb;

	// write response
	logic       bvalid;
	logic       bready;
	axi_id_t    bid;
	axi_resp_t  bresp;

	// read address and data
	logic       arvalid;
	logic       arready;
	axi_id_t    arid;
	addr_t      araddr;
	axi_len_t   arlen;
	axi_size_t  arsize;
	axi_burst_t arburst;
	logic       rvalid;
	logic       rready;
	logic       rlast;
	axi_id_t    rid;
	data_t      rdata;
	axi_resp_t  rresp;

	mem_store_path i_mem_store_path (.*);

	mem_load_path i_mem_load_path (.*);

	axi_sram_slave i_axi_sram_slave (.*);

	assign stall_mem = store_pending | load_pending;

endmodule

// ==== dv/mem_subsys_asserts.sv ====
// ########################################
// AXI handshake and burst length checks
// attached to the memory port top level
// with bind
// ########################################

`timescale 1ns/1ps

module mem_subsys_asserts (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  mem_wr_en,
	input logic                  mem_rd_en,
	input mem_axi_pkg::addr_t    addr_mem_wr,
	input mem_axi_pkg::addr_t    addr_mem_rd,
	input logic                  awvalid,
	input logic                  awready,
	input mem_axi_pkg::addr_t    awaddr,
	input mem_axi_pkg::axi_len_t awlen,
	input logic                  wvalid,
	input logic                  wready,
	input logic                  wlast,
	input mem_axi_pkg::data_t    wdata,
	input mem_axi_pkg::strb_t    wstrb,
	input logic                  arvalid,
	input logic                  arready,
	input mem_axi_pkg::addr_t    araddr,
	input mem_axi_pkg::axi_len_t arlen,
	input logic                  rvalid,
	input logic                  rready,
	input logic                  rlast
);
	import mem_axi_pkg::*;

	// beats seen so far in the current write and read bursts
	axi_len_t w_beats;
	axi_len_t w_len_q;
	logic     w_pair;
	axi_len_t r_beats;
	logic     r_pair;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			w_beats <= '0;
			r_beats <= '0;
		end else begin
			if (awvalid && awready) begin
				w_beats <= '0;
			end else if (wvalid && wready) begin
				w_beats <= w_beats + 8'd1;
			end
			if (arvalid && arready) begin
				r_beats <= '0;
			end else if (rvalid && rready) begin
				r_beats <= r_beats + 8'd1;
			end
		end
	end

	// burst length and core offset as seen at the address transfer
	always_ff @(posedge clk) begin
		if (awvalid && awready) begin
			w_len_q <= awlen;
			w_pair  <= (addr_mem_wr[2:0] != 3'd0);
		end
		if (arvalid && arready) begin
			r_pair <= (addr_mem_rd[2:0] != 3'd0);
		end
	end

	aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
		awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen))
		else $error("awvalid dropped or AW payload changed before awready");

	w_hold: assert property (@(posedge clk) disable iff (!rst_n)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb) && $stable(wlast))
		else $error("wvalid dropped or W payload changed before wready");

	ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
		else $error("arvalid dropped or AR payload changed before arready");

	// wlast sits on the beat that awlen announced
	w_len: assert property (@(posedge clk) disable iff (!rst_n)
		wvalid |-> wlast == (w_beats == w_len_q))
		else $error("wlast does not match the awlen of the burst");

	// two beats exactly when the byte offset is non-zero
	w_pair_len: assert property (@(posedge clk) disable iff (!rst_n)
		wvalid && wready && wlast |-> w_beats == axi_len_t'(w_pair))
		else $error("write burst beat count does not match the store offset");

	r_pair_len: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && rready |-> rlast == (r_beats == axi_len_t'(r_pair)))
		else $error("read burst beat count does not match the load offset");

	one_enable: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_wr_en && mem_rd_en))
		else $error("load and store enables high together");

endmodule

bind mem_subsys_top mem_subsys_asserts i_mem_subsys_asserts (
	.clk         (clk),
	.rst_n       (rst_n),
	.mem_wr_en   (mem_wr_en),
	.mem_rd_en   (mem_rd_en),
	.addr_mem_wr (addr_mem_wr),
	.addr_mem_rd (addr_mem_rd),
	.awvalid     (awvalid),
	.awready     (awready),
	.awaddr      (awaddr),
	.awlen       (awlen),
	.wvalid      (wvalid),
	.wready      (wready),
	.wlast       (wlast),
	.wdata       (wdata),
	.wstrb       (wstrb),
	.arvalid     (arvalid),
	.arready     (arready),
	.araddr      (araddr),
	.arlen       (arlen),
	.rvalid      (rvalid),
	.rready      (rready),
	.rlast       (rlast)
);

// ==== dv/mem_subsys_tb.sv ====
// ########################################
// testbench for the AXI memory port; it
// fills the test memory and runs directed
// and random loads and stores against a
// shadow memory
// ########################################

`timescale 1ns/1ps

module mem_subsys_tb;
	import mem_axi_pkg::*;

	localparam int WAIT_LIMIT   = 200;
	localparam int RANDOM_OPS   = 300;
	localparam int SEED         = 59;
	localparam int WINDOW_BYTES = MEM_WORDS * 8;

	typedef logic [10:0] byte_idx_t;

	logic  clk;
	logic  rst_n;
	logic  mem_wr_en;
	logic  mem_rd_en;
	addr_t addr_mem_wr;
	addr_t addr_mem_rd;
	data_t data_mem_wr;
	strb_t strb_mem_wr;
	data_t data_mem_rd;
	logic  stall_mem;

	// byte image of the test memory
	logic [7:0] shadow [WINDOW_BYTES];

	logic  check_armed;
	data_t exp_data;
	string test_name;
	int    value_errors;
	int    timeout_errors;
	int    stall_errors;
	int    loads_checked;

	mem_subsys_top i_mem_subsys_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.mem_wr_en   (mem_wr_en),
		.mem_rd_en   (mem_rd_en),
		.addr_mem_wr (addr_mem_wr),
		.addr_mem_rd (addr_mem_rd),
		.data_mem_wr (data_mem_wr),
		.strb_mem_wr (strb_mem_wr),
		.data_mem_rd (data_mem_rd),
		.stall_mem   (stall_mem)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// byte i of the result sits at addr + i
	function automatic data_t expected_load(input int addr);
		data_t val;
		for (int i = 0; i < 8; i++) begin
			val[i*8 +: 8] = shadow[byte_idx_t'(addr + i)];
		end
		return val;
	endfunction

	function automatic data_t fill_word(input int idx);
		return {16'hc0de, 16'(idx), 16'(~idx), 16'(idx * 37 + 5)};
	endfunction

	task automatic shadow_write(input int addr, input data_t data, input strb_t strb);
		for (int i = 0; i < 8; i++) begin
			if (strb[i]) begin
				shadow[byte_idx_t'(addr + i)] = data[i*8 +: 8];
			end
		end
	endtask

	task automatic check_idle(input string what, input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			assert (stall_mem === 1'b0) else begin
				$display("stall_mem was high %s with both enables low", what);
				stall_errors++;
			end
		end
	endtask

	// ends at the first low stall_mem and checks the minimum latency
	task automatic wait_for_completion(input string what, input int min_stall);
		int stalled;
		bit done;
		stalled = 0;
		done = 1'b0;
		while (!done && stalled < WAIT_LIMIT) begin
			@(negedge clk);
			if (!stall_mem) begin
				done = 1'b1;
			end else begin
				stalled++;
			end
		end
		assert (done) else begin
			$display("%s did not complete within %0d cycles", what, WAIT_LIMIT);
			timeout_errors++;
		end
		if (done) begin
			assert (stalled >= min_stall) else begin
				$display("%s completed after %0d stall cycles, fewer than %0d",
					what, stalled, min_stall);
				stall_errors++;
			end
		end
	endtask

	task automatic store_bytes(input int addr, input data_t data, input strb_t strb,
			input string what);
		@(posedge clk);
		#1;
		mem_wr_en   = 1'b1;
		addr_mem_wr = addr_t'(addr);
		data_mem_wr = data;
		strb_mem_wr = strb;
		wait_for_completion(what, (addr % 8 != 0) ? 3 : 2);
		@(posedge clk);
		#1;
		mem_wr_en = 1'b0;
		shadow_write(addr, data, strb);
	endtask

	task automatic load_check(input int addr, input string what);
		@(posedge clk);
		#1;
		mem_rd_en   = 1'b1;
		addr_mem_rd = addr_t'(addr);
		exp_data    = expected_load(addr);
		test_name   = what;
		check_armed = 1'b1;
		wait_for_completion(what, (addr % 8 != 0) ? 2 : 1);
		@(posedge clk);
		#1;
		mem_rd_en   = 1'b0;
		check_armed = 1'b0;
	endtask

	// compares the load result in its completion cycle
	always @(negedge clk) begin
		if (check_armed && mem_rd_en && !stall_mem) begin
			assert (data_mem_rd === exp_data) else begin
				$display("Error: %s at %h expected %h actual %h",
					test_name, addr_mem_rd, exp_data, data_mem_rd);
				value_errors++;
			end
			loads_checked++;
		end
	end

	initial begin
		int    addr;
		int    idx;
		data_t data;
		strb_t strb;

		void'($urandom(SEED));
		rst_n          = 1'b0;
		mem_wr_en      = 1'b0;
		mem_rd_en      = 1'b0;
		addr_mem_wr    = '0;
		addr_mem_rd    = '0;
		data_mem_wr    = '0;
		strb_mem_wr    = '0;
		check_armed    = 1'b0;
		exp_data       = '0;
		test_name      = "";
		value_errors   = 0;
		timeout_errors = 0;
		stall_errors   = 0;
		loads_checked  = 0;

		check_idle("during reset", 10);
		@(posedge clk);
		#1;
		rst_n = 1'b1;
		check_idle("after reset", 3);

		// every word gets a known value first
		for (int w = 0; w < MEM_WORDS; w++) begin
			store_bytes(w * 8, fill_word(w), 8'hff, "fill");
		end

		for (int k = 0; k < 16; k++) begin
			idx  = $urandom_range(0, MEM_WORDS - 1);
			data = {$urandom, $urandom};
			store_bytes(idx * 8, data, 8'hff, "aligned");
			load_check(idx * 8, "aligned");
			load_check(((idx + 7) % MEM_WORDS) * 8, "aligned");
		end

		for (int off = 1; off < 8; off++) begin
			idx  = off * 20;
			addr = idx * 8 + off;
			data = {$urandom, $urandom};
			store_bytes(addr, data, 8'hff, "unaligned");
			load_check(addr, "unaligned");
			load_check(idx * 8, "unaligned low word");
			load_check(idx * 8 + 8, "unaligned high word");
		end

		for (int k = 0; k < 24; k++) begin
			addr = $urandom_range(0, WINDOW_BYTES - 8);
			data = {$urandom, $urandom};
			strb = strb_t'($urandom);
			store_bytes(addr, data, strb, "partial strobe");
			load_check(addr, "partial strobe");
			load_check(addr - addr % 8, "partial strobe");
		end

		for (int k = 0; k < RANDOM_OPS; k++) begin
			addr = $urandom_range(0, WINDOW_BYTES - 8);
			if ($urandom_range(0, 1) == 1) begin
				data = {$urandom, $urandom};
				strb = strb_t'($urandom);
				store_bytes(addr, data, strb, "random mix");
			end else begin
				load_check(addr, "random mix");
			end
		end

		check_idle("after the last request", 3);

		$display("errors: %0d value, %0d timeout, %0d stall; %0d loads checked",
			value_errors, timeout_errors, stall_errors, loads_checked);
		if (value_errors + timeout_errors + stall_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
logic/mem_axi_pkg.sv
logic/mem_store_path.sv
logic/mem_load_path.sv
logic/axi_sram_slave.sv
logic/mem_subsys_top.sv
dv/mem_subsys_asserts.sv
dv/mem_subsys_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the memory port testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
	--top-module mem_subsys_tb -Mdir obj_dir -o mem_subsys_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/mem_subsys_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Result: PASSED"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1
